/* Makefile */
# Verilator build and run of the platformer core testbench

VERILATOR ?= verilator
TOP ?= platformerTb
LINT_TOP ?= platformerTop
FILELIST ?= platformer.f
OBJDIR ?= obj_dir
EXTRA_FLAGS ?=

SOURCES := $(shell cat $(FILELIST))
SIM := $(OBJDIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) --binary --timing --assert --top-module $(TOP) --Mdir $(OBJDIR) \
		-f $(FILELIST) $(EXTRA_FLAGS)

run: $(SIM)
	./$(SIM)

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(LINT_TOP) \
		rtl/platformerPkg.sv rtl/stepTimer.sv rtl/playerMotion.sv rtl/drawScanner.sv \
		rtl/pixelShader.sv rtl/levelControl.sv rtl/platformerTop.sv $(EXTRA_FLAGS)

clean:
	rm -rf $(OBJDIR)

/* platformer.f */
rtl/platformerPkg.sv
rtl/stepTimer.sv
rtl/playerMotion.sv
rtl/drawScanner.sv
rtl/pixelShader.sv
rtl/levelControl.sv
rtl/platformerTop.sv
verif/platformerTb.sv

/* rtl/drawScanner.sv */
// raster scan over the screen or the sprite box, one coordinate per cycle
`timescale 1ns/1ps

module drawScanner (
	input  logic clk,
	input  logic rstN,
	input  logic drawGo,
	input  platformerPkg::drawOp_t drawOp,
	input  platformerPkg::spritePos_t pos,
	output logic scanValid,
	output logic [platformerPkg::X_BITS-1:0] scanX,
	output logic [platformerPkg::Y_BITS-1:0] scanY,
	output platformerPkg::drawOp_t scanOp,
	output logic scanDone
);

	logic active;
	logic [platformerPkg::X_BITS-1:0] originX, colCnt, lastCol;
	logic [platformerPkg::Y_BITS-1:0] originY, rowCnt, lastRow;

	// box size follows the latched opcode
	assign lastCol = (scanOp == platformerPkg::opStage) ?
		platformerPkg::X_BITS'(platformerPkg::SCREEN_W - 1) :
		platformerPkg::X_BITS'(platformerPkg::SPRITE_W - 1);
	assign lastRow = (scanOp == platformerPkg::opStage) ?
		platformerPkg::Y_BITS'(platformerPkg::SCREEN_H - 1) :
		platformerPkg::Y_BITS'(platformerPkg::SPRITE_H - 1);

	assign scanValid = active;
	assign scanX = originX + colCnt;
	assign scanY = originY + rowCnt;
	assign scanDone = active && (colCnt == lastCol) && (rowCnt == lastRow);

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			active <= 1'b0;
			scanOp <= platformerPkg::opStage;
			originX <= '0;
			originY <= '0;
			colCnt <= '0;
			rowCnt <= '0;
		end else if (drawGo) begin
			active <= 1'b1;
			scanOp <= drawOp;
			originX <= (drawOp == platformerPkg::opStage) ? '0 : pos.x;
			originY <= (drawOp == platformerPkg::opStage) ? '0 : pos.y;
			colCnt <= '0;
			rowCnt <= '0;
		end else if (active) begin
			if (colCnt == lastCol) begin
				colCnt <= '0;
				if (rowCnt == lastRow)
					active <= 1'b0; // box finished
				else
					rowCnt <= rowCnt + 1'b1;
			end else begin
				colCnt <= colCnt + 1'b1;
			end
		end
	end

endmodule

/* rtl/levelControl.sv */
// game FSM: latches the level, sequences stage and sprite drawing, and runs erase-step-redraw
`timescale 1ns/1ps

module levelControl (
	input  logic clk,
	input  logic rstN,
	input  logic start,
	input  platformerPkg::level_t level,
	input  platformerPkg::playerCmd_t buttons,
	input  logic tick,
	input  logic scanDone,
	input  logic grounded,
	input  logic atLeft,
	input  logic atRight,
	input  logic jumpTop,
	output platformerPkg::level_t curLevel,
	output logic spawn,
	output logic drawGo,
	output platformerPkg::drawOp_t drawOp,
	output platformerPkg::stepKind_t stepKind
);

	platformerPkg::gameState_t state;
	platformerPkg::stepKind_t pendStep; // step to apply once the erase is done
	platformerPkg::stepKind_t moveStep;
	logic rising;
	logic startOk;

	// a new level can only be loaded between draws
	assign startOk = start && (state == platformerPkg::waitLevel || state == platformerPkg::idle);

	assign spawn = (state == platformerPkg::spawnSprite); // sprite reset lands before the draw

	// step chosen on a tick, by priority
	always_comb begin
		moveStep = platformerPkg::stepNone;
		if (!grounded || jumpTop) begin
			// airborne: keep rising until the top, then fall
			moveStep = (rising && !jumpTop) ? platformerPkg::stepUp : platformerPkg::stepDown;
		end else if (buttons.right && !atRight) begin
			moveStep = platformerPkg::stepRight;
		end else if (buttons.left && !atLeft) begin
			moveStep = platformerPkg::stepLeft;
		end else if (buttons.up) begin
			moveStep = platformerPkg::stepUp; // take off
		end
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			state <= platformerPkg::waitLevel;
			curLevel <= '0;
			drawGo <= 1'b0;
			drawOp <= platformerPkg::opStage;
			stepKind <= platformerPkg::stepNone;
			pendStep <= platformerPkg::stepNone;
			rising <= 1'b0;
		end else begin
			drawGo <= 1'b0; // strobes
			stepKind <= platformerPkg::stepNone;
			if (startOk) begin
				curLevel <= (level > platformerPkg::level_t'(platformerPkg::NUM_LEVELS - 1)) ?
					'0 : level;
				rising <= 1'b0;
				state <= platformerPkg::drawStage;
				drawGo <= 1'b1;
				drawOp <= platformerPkg::opStage;
			end else begin
				case (state)
				platformerPkg::waitLevel: begin
					state <= platformerPkg::waitLevel;
				end
				platformerPkg::drawStage: begin
					if (scanDone)
						state <= platformerPkg::spawnSprite;
				end
				platformerPkg::spawnSprite: begin
					state <= platformerPkg::drawSprite;
					drawGo <= 1'b1;
					drawOp <= platformerPkg::opSprite;
				end
				platformerPkg::drawSprite: begin
					// after an erase the step is out this cycle, redraw follows
					if (stepKind != platformerPkg::stepNone) begin
						drawGo <= 1'b1;
						drawOp <= platformerPkg::opSprite;
					end
					if (scanDone)
						state <= platformerPkg::idle;
				end
				platformerPkg::idle: begin
					if (tick && moveStep != platformerPkg::stepNone) begin
						pendStep <= moveStep;
						rising <= (moveStep == platformerPkg::stepUp);
						state <= platformerPkg::eraseSprite;
						drawGo <= 1'b1;
						drawOp <= platformerPkg::opErase;
					end
				end
				platformerPkg::eraseSprite: begin
					if (scanDone) begin
						stepKind <= pendStep;
						state <= platformerPkg::drawSprite;
					end
				end
				default: state <= platformerPkg::waitLevel;
				endcase
			end
		end
	end

endmodule

/* rtl/pixelShader.sv */
// colours each scanned coordinate and registers it onto the pixel-write port
`timescale 1ns/1ps

module pixelShader (
	input  logic clk,
	input  logic rstN,
	input  platformerPkg::level_t curLevel,
	input  platformerPkg::spritePos_t pos,
	input  logic scanValid,
	input  logic [platformerPkg::X_BITS-1:0] scanX,
	input  logic [platformerPkg::Y_BITS-1:0] scanY,
	input  platformerPkg::drawOp_t scanOp,
	output platformerPkg::pixelWrite_t pixel
);

	logic [platformerPkg::COLOUR_BITS-1:0] bgColour, colour, colourQ;
	logic [platformerPkg::X_BITS-1:0] eyeX, xQ;
	logic [platformerPkg::Y_BITS-1:0] yQ;
	logic writeEnQ;

	assign bgColour = (scanY >= platformerPkg::FLOOR_ROW[curLevel]) ?
		platformerPkg::GROUND_COLOUR : platformerPkg::SKY_COLOUR[curLevel];

	// eye sits on the column the sprite faces
	assign eyeX = pos.facingRight ?
		pos.x + platformerPkg::X_BITS'(platformerPkg::SPRITE_W - 1) : pos.x;

	always_comb begin
		if (scanOp == platformerPkg::opSprite)
			colour = (scanX == eyeX) ? platformerPkg::EYE_COLOUR : platformerPkg::BODY_COLOUR;
		else
			colour = bgColour; // stage and erase
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN)
			writeEnQ <= 1'b0;
		else
			writeEnQ <= scanValid;
	end

	always_ff @(posedge clk) begin
		xQ <= scanX;
		yQ <= scanY;
		colourQ <= colour;
	end

	assign pixel = '{writeEn: writeEnQ, x: xQ, y: yQ, colour: colourQ};

endmodule

/* rtl/platformerPkg.sv */
// shared geometry, colours, level tables and types for the platformer core; referenced by scope
package platformerPkg;

	localparam int SCREEN_W = 32;
	localparam int SCREEN_H = 24;
	localparam int SPRITE_W = 4;
	localparam int SPRITE_H = 4;

	localparam int X_BITS = 5;
	localparam int Y_BITS = 5;
	localparam int COLOUR_BITS = 12;

	localparam int JUMP_HEIGHT = 6; // rising rows per jump
	localparam int JUMP_BITS = $clog2(JUMP_HEIGHT + 1);
	localparam int STEP_CYCLES = 64; // clocks per movement tick
	localparam int STEP_BITS = $clog2(STEP_CYCLES);

	localparam logic [X_BITS-1:0] SPAWN_X = 5'd2;

	localparam int NUM_LEVELS = 3;

	// first ground row of each level
	localparam logic [Y_BITS-1:0] FLOOR_ROW [NUM_LEVELS] = '{5'd20, 5'd18, 5'd16};

	localparam logic [COLOUR_BITS-1:0] SKY_COLOUR [NUM_LEVELS] = '{
		12'h6bf, // day
		12'h48d, // dusk
		12'h224  // night
	};

	localparam logic [COLOUR_BITS-1:0] GROUND_COLOUR = 12'h852;
	localparam logic [COLOUR_BITS-1:0] BODY_COLOUR = 12'hd21;
	localparam logic [COLOUR_BITS-1:0] EYE_COLOUR = 12'hfff;

	typedef logic [1:0] level_t; // 0 to NUM_LEVELS-1

	typedef enum logic [2:0] {
		waitLevel,
		drawStage,
		spawnSprite,
		drawSprite,
		idle,
		eraseSprite
	} gameState_t;

	typedef enum logic [1:0] {
		opStage, // whole screen background
		opSprite, // sprite box in sprite colours
		opErase // sprite box in background colours
	} drawOp_t;

	typedef enum logic [2:0] {
		stepNone,
		stepLeft,
		stepRight,
		stepUp,
		stepDown
	} stepKind_t;

	typedef struct packed {
		logic left;
		logic right;
		logic up;
	} playerCmd_t;

	typedef struct packed {
		logic [X_BITS-1:0] x; // top-left column
		logic [Y_BITS-1:0] y; // top-left row
		logic facingRight;
	} spritePos_t;

	typedef struct packed {
		logic writeEn;
		logic [X_BITS-1:0] x;
		logic [Y_BITS-1:0] y;
		logic [COLOUR_BITS-1:0] colour;
	} pixelWrite_t;

endpackage

/* rtl/platformerTop.sv */
// top level of the platformer core: game FSM, tick timer, motion, scanner and shader
`timescale 1ns/1ps

module platformerTop (
	input  logic clk,
	input  logic rstN,
	input  logic start,
	input  platformerPkg::level_t level,
	input  platformerPkg::playerCmd_t buttons,
	output platformerPkg::pixelWrite_t pixel
);

	platformerPkg::level_t curLevel;
	platformerPkg::drawOp_t drawOp, scanOp;
	platformerPkg::stepKind_t stepKind;
	platformerPkg::spritePos_t pos;
	logic tick, spawn, drawGo, scanDone, scanValid;
	logic grounded, atLeft, atRight, jumpTop;
	logic [platformerPkg::X_BITS-1:0] scanX;
	logic [platformerPkg::Y_BITS-1:0] scanY;

	levelControl uLevelControl (
		.clk(clk), .rstN(rstN), .start(start), .level(level), .buttons(buttons),
		.tick(tick), .scanDone(scanDone), .grounded(grounded), .atLeft(atLeft),
		.atRight(atRight), .jumpTop(jumpTop), .curLevel(curLevel), .spawn(spawn),
		.drawGo(drawGo), .drawOp(drawOp), .stepKind(stepKind)
	);

	stepTimer uStepTimer (.clk(clk), .rstN(rstN), .tick(tick));

	playerMotion uPlayerMotion (
		.clk(clk), .rstN(rstN), .curLevel(curLevel), .stepKind(stepKind), .spawn(spawn),
		.pos(pos), .grounded(grounded), .atLeft(atLeft), .atRight(atRight), .jumpTop(jumpTop)
	);

	drawScanner uDrawScanner (
		.clk(clk), .rstN(rstN), .drawGo(drawGo), .drawOp(drawOp), .pos(pos),
		.scanValid(scanValid), .scanX(scanX), .scanY(scanY), .scanOp(scanOp),
		.scanDone(scanDone)
	);

	pixelShader uPixelShader (
		.clk(clk), .rstN(rstN), .curLevel(curLevel), .pos(pos), .scanValid(scanValid),
		.scanX(scanX), .scanY(scanY), .scanOp(scanOp), .pixel(pixel)
	);

endmodule

/* rtl/playerMotion.sv */
// sprite position, facing and jump counter, with ground, edge and jump-top status
`timescale 1ns/1ps

module playerMotion (
	input  logic clk,
	input  logic rstN,
	input  platformerPkg::level_t curLevel,
	input  platformerPkg::stepKind_t stepKind,
	input  logic spawn,
	output platformerPkg::spritePos_t pos,
	output logic grounded,
	output logic atLeft,
	output logic atRight,
	output logic jumpTop
);

	logic [platformerPkg::Y_BITS-1:0] standY; // top row when standing on the floor
	logic [platformerPkg::JUMP_BITS-1:0] jumpCnt;

	assign standY = platformerPkg::FLOOR_ROW[curLevel] -
		platformerPkg::Y_BITS'(platformerPkg::SPRITE_H);

	assign grounded = (pos.y == standY);
	assign atLeft = (pos.x == '0);
	assign atRight = (pos.x ==
		platformerPkg::X_BITS'(platformerPkg::SCREEN_W - platformerPkg::SPRITE_W));
	assign jumpTop = (jumpCnt == platformerPkg::JUMP_BITS'(platformerPkg::JUMP_HEIGHT));

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			pos.x <= platformerPkg::SPAWN_X;
			pos.y <= platformerPkg::FLOOR_ROW[0] - platformerPkg::Y_BITS'(platformerPkg::SPRITE_H);
			pos.facingRight <= 1'b1;
			jumpCnt <= '0;
		end else if (spawn) begin
			pos.x <= platformerPkg::SPAWN_X;
			pos.y <= standY;
			pos.facingRight <= 1'b1;
			jumpCnt <= '0;
		end else begin
			case (stepKind)
			platformerPkg::stepRight: begin
				if (!atRight)
					pos.x <= pos.x + 1'b1;
				pos.facingRight <= 1'b1;
			end
			platformerPkg::stepLeft: begin
				if (!atLeft)
					pos.x <= pos.x - 1'b1;
				pos.facingRight <= 1'b0;
			end
			platformerPkg::stepUp: begin
				pos.y <= pos.y - 1'b1;
				jumpCnt <= jumpCnt + 1'b1;
			end
			platformerPkg::stepDown: begin
				pos.y <= pos.y + 1'b1;
				if (pos.y + 1'b1 == standY)
					jumpCnt <= '0; // landed
			end
			default: ;
			endcase
		end
	end

endmodule

/* rtl/stepTimer.sv */
// free-running divider giving one movement tick every STEP_CYCLES clocks
`timescale 1ns/1ps

module stepTimer (
	input  logic clk,
	input  logic rstN,
	output logic tick
);

	logic [platformerPkg::STEP_BITS-1:0] count;

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			count <= '0;
			tick <= 1'b0;
		end else begin
			tick <= (count == platformerPkg::STEP_BITS'(platformerPkg::STEP_CYCLES - 1)); // on wrap
			if (count == platformerPkg::STEP_BITS'(platformerPkg::STEP_CYCLES - 1))
				count <= '0;
			else
				count <= count + 1'b1;
		end
	end

endmodule

/* verif/platformerTb.sv */
// self-checking testbench for platformerTop; run through the Makefile or any simulator with the file list
`timescale 1ns/1ps

module platformerTb;

	localparam int WRITE_TIMEOUT = 4 * platformerPkg::STEP_CYCLES; // cycles to wait for one write
	localparam int QUIET_CYCLES = platformerPkg::STEP_CYCLES + 8; // always spans a tick
	localparam int EDGE_X = platformerPkg::SCREEN_W - platformerPkg::SPRITE_W;
	localparam logic [31:0] SEED = 32'h1b46_ede9;

	logic clk;
	logic rstN;
	logic start;
	platformerPkg::level_t level;
	platformerPkg::playerCmd_t buttons;
	platformerPkg::pixelWrite_t pixel;

	// reference model of the game
	platformerPkg::level_t curLvl;
	int posX;
	int posY;
	bit faceRight;
	int expWrites;
	int seenWrites;
	logic [31:0] rng;

	platformerTop UUT (
		.clk(clk), .rstN(rstN), .start(start), .level(level), .buttons(buttons), .pixel(pixel)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] v;
		v = s;
		v = v ^ (v << 13);
		v = v ^ (v >> 17);
		v = v ^ (v << 5);
		return v;
	endfunction

	// sky above the floor row, ground from it down
	function automatic logic [11:0] backColour(input platformerPkg::level_t lvl, input int y);
		if (y >= int'(platformerPkg::FLOOR_ROW[lvl]))
			return platformerPkg::GROUND_COLOUR;
		else
			return platformerPkg::SKY_COLOUR[lvl];
	endfunction

	task automatic showMismatch(input string test, input string what, input int expVal,
		input int actVal);
		$display("STATUS: FAIL");
		$display("FAIL %s: %s expected 0x%0h actual 0x%0h", test, what, expVal, actVal);
		$fatal(1, "value mismatch");
	endtask

	task automatic abortRun(input string msg);
		$display("STATUS: FAIL");
		$display("%s", msg);
		$fatal(1, "run aborted");
	endtask

	// every write on the port lands on the screen with known values
	always @(negedge clk) begin
		if (rstN && pixel.writeEn) begin
			seenWrites++;
			assert (!$isunknown(pixel)) else abortRun("pixel write carries unknown bits");
			assert (int'(pixel.y) < platformerPkg::SCREEN_H)
				else abortRun("pixel write below the bottom of the screen");
		end
	end

	task automatic setButtons(input bit l, input bit r, input bit u);
		@(posedge clk);
		#1;
		buttons.left = l;
		buttons.right = r;
		buttons.up = u;
	endtask

	task automatic nextWrite(input string test);
		int waited;
		waited = 0;
		@(negedge clk);
		while (!pixel.writeEn) begin
			waited++;
			assert (waited < WRITE_TIMEOUT)
				else abortRun($sformatf("%s: timed out waiting for a pixel write", test));
			@(negedge clk);
		end
	endtask

	task automatic expectPixel(input string test, input int x, input int y,
		input logic [11:0] colour);
		nextWrite(test);
		expWrites++;
		assert (int'(pixel.x) == x) else showMismatch(test, "x", x, int'(pixel.x));
		assert (int'(pixel.y) == y) else showMismatch(test, "y", y, int'(pixel.y));
		assert (pixel.colour == colour)
			else showMismatch(test, "colour", int'(colour), int'(pixel.colour));
	endtask

	task automatic expectQuiet(input string test, input int cycles);
		repeat (cycles) begin
			@(negedge clk);
			assert (!pixel.writeEn)
				else abortRun($sformatf("%s: pixel write where none was due", test));
		end
	endtask

	// sprite box in row-major order, either drawn or erased
	task automatic expectBox(input string test, input bit isSprite, input int x, input int y,
		input bit facing);
		int eyeCol;
		logic [11:0] colour;
		eyeCol = facing ? platformerPkg::SPRITE_W - 1 : 0;
		for (int r = 0; r < platformerPkg::SPRITE_H; r++) begin
			for (int c = 0; c < platformerPkg::SPRITE_W; c++) begin
				if (!isSprite)
					colour = backColour(curLvl, y + r);
				else if (c == eyeCol)
					colour = platformerPkg::EYE_COLOUR;
				else
					colour = platformerPkg::BODY_COLOUR;
				expectPixel(test, x + c, y + r, colour);
			end
		end
	endtask

	task automatic loadLevel(input platformerPkg::level_t lvl);
		@(posedge clk);
		#1;
		start = 1'b1;
		level = lvl;
		@(posedge clk);
		#1;
		start = 1'b0;
		curLvl = lvl;
		for (int y = 0; y < platformerPkg::SCREEN_H; y++) begin
			for (int x = 0; x < platformerPkg::SCREEN_W; x++)
				expectPixel("stage", x, y, backColour(curLvl, y));
		end
		posX = int'(platformerPkg::SPAWN_X);
		posY = int'(platformerPkg::FLOOR_ROW[curLvl]) - platformerPkg::SPRITE_H; // on the floor
		faceRight = 1'b1;
		expectBox("spawn", 1'b1, posX, posY, faceRight);
	endtask

	// hold one direction for one tick; at an edge nothing may be drawn
	task automatic tryStep(input string test, input bit goRight);
		setButtons(!goRight, goRight, 1'b0);
		if (goRight ? posX < EDGE_X : posX > 0) begin
			expectBox(test, 1'b0, posX, posY, faceRight);
			posX = goRight ? posX + 1 : posX - 1;
			faceRight = goRight;
			expectBox(test, 1'b1, posX, posY, faceRight);
		end else begin
			expectQuiet(test, QUIET_CYCLES);
			assert (int'(UUT.pos.x) == posX) else showMismatch(test, "clamped x", posX,
				int'(UUT.pos.x));
		end
	endtask

	task automatic checkJump();
		int floorY;
		floorY = int'(platformerPkg::FLOOR_ROW[curLvl]) - platformerPkg::SPRITE_H;
		setButtons(1'b0, 1'b0, 1'b1);
		for (int i = 0; i < 2 * platformerPkg::JUMP_HEIGHT; i++) begin
			expectBox("jump", 1'b0, posX, posY, faceRight);
			posY = (i < platformerPkg::JUMP_HEIGHT) ? posY - 1 : posY + 1;
			expectBox("jump", 1'b1, posX, posY, faceRight);
			if (i == 0)
				setButtons(1'b0, 1'b1, 1'b0); // right held in mid-air
			if (i == 2 * platformerPkg::JUMP_HEIGHT - 2)
				setButtons(1'b0, 1'b0, 1'b0); // let go before landing
		end
		assert (int'(UUT.pos.y) == floorY)
			else showMismatch("jump", "landing row", floorY, int'(UUT.pos.y));
		expectQuiet("jump", QUIET_CYCLES);
	endtask

	initial begin
		int count;
		bit goRight;
		rstN = 1'b0;
		start = 1'b0;
		level = '0;
		buttons = '0;
		curLvl = '0;
		posX = 0;
		posY = 0;
		faceRight = 1'b1;
		expWrites = 0;
		seenWrites = 0;
		rng = SEED;
		repeat (16) @(posedge clk);
		#1;
		rstN = 1'b1;

		expectQuiet("reset", 2 * platformerPkg::STEP_CYCLES);

		for (int l = 0; l < platformerPkg::NUM_LEVELS; l++)
			loadLevel(platformerPkg::level_t'(l));

		for (int i = 0; i < 3; i++)
			tryStep("moveRight", 1'b1);
		for (int i = 0; i < 3; i++)
			tryStep("moveLeft", 1'b0); // eye flips on the first one

		for (int round = 0; round < 6; round++) begin
			rng = xorshift(rng);
			goRight = rng[0];
			count = 1 + int'(rng[15:8]) % 31;
			repeat (count) tryStep("bounds", goRight);
		end
		while (posX < EDGE_X)
			tryStep("edgeRight", 1'b1);
		tryStep("edgeRight", 1'b1);
		while (posX > 0)
			tryStep("edgeLeft", 1'b0);
		tryStep("edgeLeft", 1'b0);

		checkJump();

		@(negedge clk);
		if (seenWrites != expWrites) begin
			showMismatch("total", "write count", expWrites, seenWrites);
		end else begin
			$display("STATUS: PASS");
			$finish;
		end
	end

endmodule
